/* flist.f */
+incdir+rtl
rtl/npc_pkg.sv
rtl/npc_update_if.sv
rtl/btb.sv
rtl/ras.sv
rtl/cpht.sv
rtl/npc_predictor.sv
rtl/npc_top.sv
testbench/npc_checker.sv
testbench/tb_npc.sv

/* testbench/tb_npc.sv */
`timescale 1ns/1ps
`include "npc_settings.svh"

module tb_npc;
    import npc_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int LEN_T1 = 64;
    localparam int LEN_T2 = 80;
    localparam int LEN_T3 = 80;
    localparam int LEN_T4 = 88;
    localparam int LEN_T5 = 32;
    localparam int LEN_T6 = 400;
    localparam int LIMIT  = RESET_CYCLES + LEN_T1 + LEN_T2 + LEN_T3 + LEN_T4
                          + LEN_T5 + LEN_T6 + 100;

    logic         clk;
    logic         rstn;
    logic         update_en;
    gh_index_t    pc_ex_gh_hashed;
    addr_t        npc_ex;
    branch_kind_t kind_ex;
    logic         choice_real;
    logic         mis_pdc;
    addr_t        ret_addr_ex;
    addr_t        pc;
    gh_index_t    pc_gh_hashed;
    branch_kind_t kind_pdc;
    logic         taken_pdc;
    addr_t        npc_pdc;
    logic         choice_btb_ras;
    int           errors;
    int           checks;

    logic [31:0]  lfsr = 32'he4864409;
    int           cycles = 0;
    int           err_base = 0;
    int           tests_run = 0;
    int           failed_tests = 0;
    branch_kind_t jmp_kinds [4] = '{direct_jump, jump, indirect_jump, other_jump};

    npc_top UUT (.*);

    npc_checker u_checker (.*);

    // ========================================================================
    // Clock, random source and input drivers
    // ========================================================================

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Galois LFSR stepped once per bit taken.
    function automatic logic [31:0] rnd(input int nbits);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic addr_t rand_pc();
        return addr_t'(rnd(`NPC_ADDR_WIDTH));
    endfunction

    function automatic gh_index_t rand_idx();
        return gh_index_t'(rnd(4));  // Small range so entries get reused.
    endfunction

    task automatic tick();
        @(posedge clk);
    endtask

    task automatic set_fetch(input addr_t p, input gh_index_t idx, input branch_kind_t k,
                             input logic t);
        pc           <= p;
        pc_gh_hashed <= idx;
        kind_pdc     <= k;
        taken_pdc    <= t;
    endtask

    task automatic set_update(input logic en, input gh_index_t idx, input branch_kind_t k,
                              input logic ch, input logic mis);
        update_en       <= en;
        pc_ex_gh_hashed <= idx;
        kind_ex         <= k;
        choice_real     <= ch;
        mis_pdc         <= mis;
        npc_ex          <= rand_pc();
        ret_addr_ex     <= rand_pc();
    endtask

    task automatic finish_test(input int num, input string name);
        int errs;
        @(negedge clk);
        #1;
        errs = errors - err_base;
        if (errs != 0) failed_tests++;
        tests_run++;
        err_base = errors;
        $display("Test %0d, %s: %0d errors, %s", num, name, errs, (errs == 0) ? "PASS" : "FAIL");
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("The run timed out after %0d cycles.", cycles);
            $display("sim failed");
            $finish;
        end
    end

    // ========================================================================
    // Tests
    // ========================================================================

    initial begin
        rstn <= 1'b0;
        set_update(1'b0, '0, not_jump, 1'b0, 1'b0);
        set_fetch('0, '0, not_jump, 1'b0);
        repeat (RESET_CYCLES) tick();
        rstn <= 1'b1;

        for (int i = 0; i < LEN_T1; i++) begin
            tick();
            set_update(1'b0, '0, not_jump, 1'b0, 1'b0);
            set_fetch(rand_pc(), rand_idx(), branch_kind_t'(rnd(3)), 1'(rnd(1)));
        end
        finish_test(1, "fall-through after reset");

        for (int i = 0; i < LEN_T2; i++) begin
            tick();
            if (i < 48) begin
                set_update(1'b1, rand_idx(), jmp_kinds[rnd(2)], 1'b0, 1'b0);
                set_fetch(rand_pc(), rand_idx(), not_jump, 1'b0);
            end else begin
                set_update(1'b0, '0, not_jump, 1'b0, 1'b0);
                set_fetch(rand_pc(), rand_idx(), jmp_kinds[rnd(2)], 1'b1);
            end
        end
        finish_test(2, "buffer targets");

        for (int i = 0; i < LEN_T3; i++) begin
            tick();
            if (i < 64) begin
                set_update(1'b1, rand_idx(), ret, 1'(rnd(1)), 1'b0);
                set_fetch(rand_pc(), rand_idx(), ret, 1'b0);
            end else begin
                set_update(1'b0, '0, not_jump, 1'b0, 1'b0);
                set_fetch(rand_pc(), gh_index_t'(i - 64), ret, 1'(rnd(1)));
            end
        end
        finish_test(3, "choice counters");

        // Train every index to trust the stack, then nest past the stack depth.
        for (int i = 0; i < LEN_T4; i++) begin
            tick();
            if (i < 48) begin
                set_update(1'b1, gh_index_t'(i % 16), ret, 1'b1, i == 47); // Realign pointers.
                set_fetch(rand_pc(), rand_idx(), not_jump, 1'b0);
            end else if (i < 68) begin
                set_update(1'b1, rand_idx(), call, 1'b0, 1'b0);
                set_fetch(rand_pc(), rand_idx(), not_jump, 1'b0);
            end else begin
                set_update(1'b0, '0, not_jump, 1'b0, 1'b0);
                set_fetch(rand_pc(), rand_idx(), ret, 1'b1);
            end
        end
        finish_test(4, "nested calls and returns");

        for (int i = 0; i < LEN_T5; i++) begin
            tick();
            if (i % 8 < 3) begin
                set_update(1'b1, rand_idx(), call, 1'b0, 1'b0);
                set_fetch(rand_pc(), rand_idx(), not_jump, 1'b0);
            end else if (i % 8 == 6) begin
                set_update(1'b1, rand_idx(), not_jump, 1'b0, 1'b1);  // Misprediction.
                set_fetch(rand_pc(), rand_idx(), not_jump, 1'b0);
            end else begin
                set_update(1'b0, '0, not_jump, 1'b0, 1'b0);
                set_fetch(rand_pc(), rand_idx(), ret, 1'b1);
            end
        end
        finish_test(5, "stack recovery");

        for (int i = 0; i < LEN_T6; i++) begin
            tick();
            set_update(1'(rnd(1)), rand_idx(), branch_kind_t'(rnd(3)), 1'(rnd(1)),
                       rnd(3) == 0);
            set_fetch(rand_pc(), rand_idx(), branch_kind_t'(rnd(3)), 1'(rnd(1)));
        end
        finish_test(6, "mixed random run");

        $display("Tests run %0d, failed %0d; checks %0d, errors %0d.",
                 tests_run, failed_tests, checks, errors);
        if (failed_tests == 0 && errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* testbench/npc_checker.sv */
`timescale 1ns/1ps
`include "npc_settings.svh"

module npc_checker (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  update_en,
    input  npc_pkg::gh_index_t    pc_ex_gh_hashed,
    input  npc_pkg::addr_t        npc_ex,
    input  npc_pkg::branch_kind_t kind_ex,
    input  logic                  choice_real,
    input  logic                  mis_pdc,
    input  npc_pkg::addr_t        ret_addr_ex,
    input  npc_pkg::addr_t        pc,
    input  npc_pkg::gh_index_t    pc_gh_hashed,
    input  npc_pkg::branch_kind_t kind_pdc,
    input  logic                  taken_pdc,
    input  npc_pkg::addr_t        npc_pdc,
    input  logic                  choice_btb_ras,
    output int                    errors,
    output int                    checks
);
    import npc_pkg::*;

    localparam int LEN = `NPC_STACK_LEN;

    addr_t      tgt [int];      // Only valid buffer entries exist.
    logic [1:0] ctr [int];      // Missing counters read as 01.
    addr_t      stk [LEN];
    int         sp;
    int         cp;
    addr_t      exp_npc;
    logic [1:0] exp_ctr;

    function automatic logic [1:0] ctr_at(input int idx);
        return ctr.exists(idx) ? ctr[idx] : 2'b01;
    endfunction

    function automatic addr_t predict(input logic use_stack);
        addr_t ft;
        addr_t buf_tgt;
        int    k;
        ft      = pc[0] ? addr_t'(pc + 2) : addr_t'(pc + 1);
        buf_tgt = tgt.exists(int'(pc_gh_hashed)) ? tgt[int'(pc_gh_hashed)] : ft;
        k       = int'(kind_pdc);
        if (!taken_pdc || k == 0 || k > 6) begin
            return ft;
        end
        if (kind_pdc == ret && use_stack) begin
            return stk[(sp + LEN - 1) % LEN];
        end
        return buf_tgt;
    endfunction

    task automatic reset_model();
        tgt.delete();
        ctr.delete();
        sp = 0;
        cp = 0;
        foreach (stk[i]) begin
            stk[i] = '0;
        end
    endtask

    // ========================================================================
    // State change that the coming rising edge makes
    // ========================================================================

    task automatic apply_edge();
        logic [1:0] c;
        int         sp_n;
        int         cp_n;
        sp_n = sp;
        cp_n = cp;
        if (taken_pdc && kind_pdc == ret) sp_n = sp_n - 1;   // Speculative pop.
        if (update_en) begin
            if (kind_ex != not_jump) begin
                tgt[int'(pc_ex_gh_hashed)] = npc_ex;
            end
            if (kind_ex == call) begin
                stk[cp] = ret_addr_ex;
                cp_n    = cp + 1;
                sp_n    = sp_n + 1;
            end else if (kind_ex == ret) begin
                cp_n = cp - 1;
                c    = ctr_at(int'(pc_ex_gh_hashed));
                if (choice_real) begin
                    if (c != 2'b11) c = c + 2'd1;
                end else begin
                    if (c != 2'b00) c = c - 2'd1;
                end
                ctr[int'(pc_ex_gh_hashed)] = c;
            end
            if (mis_pdc) sp_n = cp_n;                         // Recovery.
        end
        sp = (sp_n + LEN) % LEN;
        cp = (cp_n + LEN) % LEN;
    endtask

    initial begin
        errors = 0;
        checks = 0;
    end

    // Inputs change on the rising edge, so the falling edge sees them settled.
    always @(negedge clk) begin
        if (!rstn) begin
            reset_model();
        end else begin
            exp_ctr = ctr_at(int'(pc_gh_hashed));
            exp_npc = predict(exp_ctr[1]);
            checks  = checks + 1;
            if (choice_btb_ras !== exp_ctr[1]) begin
                errors = errors + 1;
                $display("** Error at %0t: choice_btb_ras %b, expected %b (index %h)",
                         $time, choice_btb_ras, exp_ctr[1], pc_gh_hashed);
            end
            if (npc_pdc !== exp_npc) begin
                errors = errors + 1;
                $display("** Error at %0t: npc_pdc %h, expected %h (pc %h, kind %0d, taken %b)",
                         $time, npc_pdc, exp_npc, pc, kind_pdc, taken_pdc);
            end
            apply_edge();
        end
    end

endmodule

/* rtl/npc_top.sv */
`timescale 1ns/1ps

module npc_top (
    input  logic                  clk,
    input  logic                  rstn,

    // Execute-stage update.
    input  logic                  update_en,
    input  npc_pkg::gh_index_t    pc_ex_gh_hashed,
    input  npc_pkg::addr_t        npc_ex,
    input  npc_pkg::branch_kind_t kind_ex,
    input  logic                  choice_real,
    input  logic                  mis_pdc,
    input  npc_pkg::addr_t        ret_addr_ex,

    // Fetch side.
    input  npc_pkg::addr_t        pc,
    input  npc_pkg::gh_index_t    pc_gh_hashed,
    input  npc_pkg::branch_kind_t kind_pdc,
    input  logic                  taken_pdc,
    output npc_pkg::addr_t        npc_pdc,
    output logic                  choice_btb_ras
);

    // ========================================================================
    // Update bundle
    // ========================================================================

    npc_update_if u_upd ();

    // Execute side of the bundle.
    assign u_upd.update_en   = update_en;
    assign u_upd.hashed_pc   = pc_ex_gh_hashed;
    assign u_upd.npc         = npc_ex;
    assign u_upd.kind        = kind_ex;
    assign u_upd.choice_real = choice_real;
    assign u_upd.mis_pdc     = mis_pdc;
    assign u_upd.ret_addr    = ret_addr_ex;

    // ========================================================================
    // Predictor
    // ========================================================================

    npc_predictor u_pred (
        .clk            (clk),
        .rstn           (rstn),
        .upd            (u_upd.pred),
        .pc             (pc),
        .pc_gh_hashed   (pc_gh_hashed),
        .kind_pdc       (kind_pdc),
        .taken_pdc      (taken_pdc),
        .npc_pdc        (npc_pdc),
        .choice_btb_ras (choice_btb_ras)
    );

endmodule

/* rtl/npc_predictor.sv */
`timescale 1ns/1ps

module npc_predictor (
    input  logic                  clk,
    input  logic                  rstn,
    npc_update_if.pred            upd,
    input  npc_pkg::addr_t        pc,
    input  npc_pkg::gh_index_t    pc_gh_hashed,
    input  npc_pkg::branch_kind_t kind_pdc,
    input  logic                  taken_pdc,
    output npc_pkg::addr_t        npc_pdc,
    output logic                  choice_btb_ras // 1 selects the stack.
);
    import npc_pkg::*;

    addr_t fallthrough;
    addr_t npc_btb;
    addr_t npc_ras;
    logic  pop_pdc;

    // Odd addresses step by two.
    assign fallthrough = pc[0] ? pc + addr_t'(2) : pc + addr_t'(1);

    assign pop_pdc = taken_pdc && (kind_pdc == ret);

    // ========================================================================
    // Tables
    // ========================================================================

    btb u_btb (
        .clk         (clk),
        .rstn        (rstn),
        .hashed_pc   (pc_gh_hashed),
        .npc_btb     (npc_btb),
        .upd         (upd),
        .fallthrough (fallthrough)
    );

    ras u_ras (
        .clk     (clk),
        .rstn    (rstn),
        .pop_pdc (pop_pdc),
        .npc_ras (npc_ras),
        .upd     (upd)
    );

    cpht u_cpht (
        .clk        (clk),
        .rstn       (rstn),
        .hashed_pc  (pc_gh_hashed),
        .choice_pdc (choice_btb_ras),
        .upd        (upd)
    );

    // ========================================================================
    // Next PC select
    // ========================================================================

    always_comb begin
        npc_pdc = fallthrough;
        if (taken_pdc) begin
            case (kind_pdc)
                direct_jump, jump, call, indirect_jump, other_jump: begin
                    npc_pdc = npc_btb;
                end
                ret: begin
                    npc_pdc = choice_btb_ras ? npc_ras : npc_btb;
                end
                default: begin
                    npc_pdc = fallthrough; // not_jump and the unused code.
                end
            endcase
        end
    end

endmodule

/* rtl/cpht.sv */
`timescale 1ns/1ps
`include "npc_settings.svh"

module cpht (
    input  logic               clk,
    input  logic               rstn,
    input  npc_pkg::gh_index_t hashed_pc,
    output logic               choice_pdc,
    npc_update_if.pred         upd
);
    import npc_pkg::*;

    localparam int unsigned DEPTH = 1 << `NPC_GH_WIDTH;

    logic [1:0] cnt [DEPTH];
    logic       upd_en;
    logic [1:0] cur;

    // Only returns have a choice to learn.
    assign upd_en = upd.update_en && (upd.kind == ret);
    assign cur    = cnt[upd.hashed_pc];

    // ========================================================================
    // Saturating counters, 1x trusts the stack
    // ========================================================================

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < DEPTH; i++) begin
                cnt[i] <= 2'b01; // Weakly trust the buffer.
            end
        end else if (upd_en) begin
            if (upd.choice_real) begin
                if (cur != 2'b11) begin
                    cnt[upd.hashed_pc] <= cur + 2'd1;
                end
            end else if (cur != 2'b00) begin
                cnt[upd.hashed_pc] <= cur - 2'd1;
            end
        end
    end

    assign choice_pdc = cnt[hashed_pc][1];

endmodule

/* rtl/ras.sv */
`timescale 1ns/1ps
`include "npc_settings.svh"

module ras (
    input  logic           clk,
    input  logic           rstn,
    input  logic           pop_pdc,
    output npc_pkg::addr_t npc_ras,
    npc_update_if.pred     upd
);
    import npc_pkg::*;

    localparam int unsigned PTR_W = $clog2(`NPC_STACK_LEN);

    typedef logic [PTR_W-1:0] ptr_t;

    addr_t stack [`NPC_STACK_LEN];
    ptr_t  spec_ptr;
    ptr_t  commit_ptr;
    ptr_t  spec_nxt;
    ptr_t  commit_nxt;
    logic  is_call;
    logic  is_ret;

    function automatic ptr_t ptr_inc(input ptr_t p);
        return (p == ptr_t'(`NPC_STACK_LEN - 1)) ? '0 : p + 1'b1;
    endfunction

    function automatic ptr_t ptr_dec(input ptr_t p);
        return (p == '0) ? ptr_t'(`NPC_STACK_LEN - 1) : p - 1'b1;
    endfunction

    assign is_call = upd.update_en && (upd.kind == call);
    assign is_ret  = upd.update_en && (upd.kind == ret);

    // ========================================================================
    // Pointer update
    // ========================================================================

    always_comb begin
        commit_nxt = commit_ptr;
        if (is_call) begin
            commit_nxt = ptr_inc(commit_ptr);
        end else if (is_ret) begin
            commit_nxt = ptr_dec(commit_ptr);
        end

        // A push and a pop in the same cycle cancel.
        spec_nxt = spec_ptr;
        case ({is_call, pop_pdc})
            2'b10:   spec_nxt = ptr_inc(spec_ptr);
            2'b01:   spec_nxt = ptr_dec(spec_ptr);
            default: spec_nxt = spec_ptr;
        endcase

        // Recovery realigns fetch with the committed stack.
        if (upd.update_en && upd.mis_pdc) begin
            spec_nxt = commit_nxt;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            spec_ptr   <= '0;
            commit_ptr <= '0;
            for (int i = 0; i < `NPC_STACK_LEN; i++) begin
                stack[i] <= '0;
            end
        end else begin
            spec_ptr   <= spec_nxt;
            commit_ptr <= commit_nxt;
            if (is_call) begin
                stack[commit_ptr] <= upd.ret_addr; // Oldest entry lost when full.
            end
        end
    end

    // Top of stack sits one below the speculative pointer.
    assign npc_ras = stack[ptr_dec(spec_ptr)];

endmodule

/* rtl/btb.sv */
`timescale 1ns/1ps
`include "npc_settings.svh"

module btb (
    input  logic               clk,
    input  logic               rstn,
    input  npc_pkg::gh_index_t hashed_pc,
    output npc_pkg::addr_t     npc_btb,
    npc_update_if.pred         upd,
    input  npc_pkg::addr_t     fallthrough
);
    import npc_pkg::*;

    localparam int unsigned DEPTH = 1 << `NPC_GH_WIDTH;

    addr_t            target_mem [DEPTH];
    logic [DEPTH-1:0] valid;
    logic             wr_en;

    // ========================================================================
    // Training
    // ========================================================================

    // Every resolved jump of any kind trains its entry.
    assign wr_en = upd.update_en && (upd.kind != not_jump);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            target_mem[upd.hashed_pc] <= upd.npc;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid <= '0;
        end else if (wr_en) begin
            valid[upd.hashed_pc] <= 1'b1;
        end
    end

    // ========================================================================
    // Lookup
    // ========================================================================

    // A miss falls through, so the selector sees a usable address either way.
    assign npc_btb = valid[hashed_pc] ? target_mem[hashed_pc] : fallthrough;

endmodule

/* rtl/npc_update_if.sv */
`timescale 1ns/1ps

interface npc_update_if;
    import npc_pkg::*;

    logic         update_en;    // Update valid this cycle.
    gh_index_t    hashed_pc;    // Hashed index of the resolved branch.
    addr_t        npc;          // Resolved next address.
    branch_kind_t kind;
    logic         choice_real;  // Stack would have been right for a return.
    logic         mis_pdc;      // Execute saw a wrong prediction.
    addr_t        ret_addr;     // Link address of a call.

    // Execute side.
    modport exec (
        output update_en,
        output hashed_pc,
        output npc,
        output kind,
        output choice_real,
        output mis_pdc,
        output ret_addr
    );

    // Predictor and its tables.
    modport pred (
        input update_en,
        input hashed_pc,
        input npc,
        input kind,
        input choice_real,
        input mis_pdc,
        input ret_addr
    );

endinterface

/* rtl/npc_pkg.sv */
`include "npc_settings.svh"

package npc_pkg;

    // ========================================================================
    // Address and index types
    // ========================================================================

    typedef logic [`NPC_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`NPC_GH_WIDTH-1:0]   gh_index_t;

    // ========================================================================
    // Branch kinds reported by decode and by execute
    // ========================================================================

    // Encoding 3'd7 is left unused. It predicts as fall-through.
    typedef enum logic [2:0] {
        not_jump      = 3'd0,
        direct_jump   = 3'd1,
        jump          = 3'd2,
        call          = 3'd3,
        ret           = 3'd4,
        indirect_jump = 3'd5,
        other_jump    = 3'd6
    } branch_kind_t;

endpackage

/* rtl/npc_settings.svh */
`ifndef NPC_SETTINGS_SVH
`define NPC_SETTINGS_SVH

// ============================================================================
// Next-PC stage sizing
// ============================================================================

// Width of the hashed fetch index, sets the table depth to 2**14.
`define NPC_GH_WIDTH 14

// Return stack entries.
`define NPC_STACK_LEN 16

// Instruction address width.
`define NPC_ADDR_WIDTH 30

`endif
